//--- src/agc_defines.svh
`ifndef AGC_DEFINES_SVH
`define AGC_DEFINES_SVH

// Datapath widths
`define AGC_LANES               8
`define AGC_IN_BITS             12
`define AGC_OUT_BITS            5
`define AGC_SCALE_BITS          17
`define AGC_SCALE_FRAC          12      // Fraction bits of the scale
`define AGC_OFFSET_BITS         16      // Units of 1/16 output LSB
`define AGC_SUMSQ_BITS          24
`define AGC_COUNT_BITS          12

// Loop start values and limits
`define AGC_START_SCALE         1500
`define AGC_START_OFFSET        0
`define AGC_START_SCALE_DELTA   30
`define AGC_START_OFFSET_DELTA  25
`define AGC_SCALE_MIN           300
`define AGC_SCALE_MAX           130000

// Window timing
`define AGC_WINDOW_CYCLES       256
`define AGC_BOOT_CYCLES         31
`define AGC_MS_SHIFT            11      // log2(window * lanes)
`define AGC_TARGET_MS           16
`define AGC_MS_ERR              2
`define AGC_OFFSET_ERR          5

// APB register map
`define AGC_APB_ADDR_BITS       8
`define AGC_APB_DATA_BITS       32
`define ADDR_CTRL               8'h00
`define ADDR_SCALE_DELTA        8'h04
`define ADDR_OFFSET_DELTA       8'h08
`define ADDR_SCALE              8'h0C
`define ADDR_OFFSET             8'h10
`define ADDR_SUMSQ              8'h14
`define ADDR_GT                 8'h18
`define ADDR_LT                 8'h1C
`define ADDR_LOOPS              8'h20

`endif

//--- src/agc_pkg.sv
`include "agc_defines.svh"

package agc_pkg;

    // One sample lane
    typedef logic signed [`AGC_IN_BITS-1:0]  in_lane_t;
    typedef logic signed [`AGC_OUT_BITS-1:0] out_lane_t;

    // Eight lanes per clock
    typedef in_lane_t  [`AGC_LANES-1:0] sample_in_t;
    typedef out_lane_t [`AGC_LANES-1:0] sample_out_t;

    typedef logic        [`AGC_SCALE_BITS-1:0]  scale_t;   // Unsigned, 12 fraction bits
    typedef logic signed [`AGC_OFFSET_BITS-1:0] offset_t;
    typedef logic        [`AGC_SUMSQ_BITS-1:0]  sumsq_t;
    typedef logic        [`AGC_COUNT_BITS-1:0]  count_t;

    typedef enum logic [2:0] {
        BOOT,
        CLEAR,
        MEASURE,
        CALC,
        APPLY
    } loop_state_t;

endpackage

//--- src/agc_apb_regs.sv
`timescale 1ns/1ps
`include "agc_defines.svh"

module agc_apb_regs (
    input  logic                          aclk,
    input  logic                          wb_rst_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [`AGC_APB_ADDR_BITS-1:0] paddr_i,
    input  logic [`AGC_APB_DATA_BITS-1:0] pwdata_i,
    input  agc_pkg::scale_t               scale_i,
    input  agc_pkg::offset_t              offset_i,
    input  agc_pkg::sumsq_t               sumsq_i,
    input  agc_pkg::count_t               gt_i,
    input  agc_pkg::count_t               lt_i,
    input  agc_pkg::count_t               loops_i,
    output logic [`AGC_APB_DATA_BITS-1:0] prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    output logic                          enable_o,
    output agc_pkg::scale_t               scale_delta_o,
    output agc_pkg::offset_t              offset_delta_o,
    output logic                          scale_wr_o,
    output logic                          offset_wr_o,
    output logic [`AGC_APB_DATA_BITS-1:0] wr_data_o
);

    localparam int DW = `AGC_APB_DATA_BITS;

    logic          wr_acc;
    logic [DW-1:0] rd_mux;

    assign pready_o  = 1'b1;   // Zero wait states
    assign pslverr_o = 1'b0;
    assign wr_acc    = psel_i && penable_i && pwrite_i;

    // Manual load strobes toward the FSM
    assign scale_wr_o  = wr_acc && (paddr_i == `ADDR_SCALE);
    assign offset_wr_o = wr_acc && (paddr_i == `ADDR_OFFSET);
    assign wr_data_o   = pwdata_i;

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            enable_o       <= 1'b1;
            scale_delta_o  <= agc_pkg::scale_t'(`AGC_START_SCALE_DELTA);
            offset_delta_o <= agc_pkg::offset_t'(`AGC_START_OFFSET_DELTA);
        end else if (wr_acc) begin
            case (paddr_i)
                `ADDR_CTRL:         enable_o       <= pwdata_i[0];
                `ADDR_SCALE_DELTA:  scale_delta_o  <= pwdata_i[`AGC_SCALE_BITS-1:0];
                `ADDR_OFFSET_DELTA: offset_delta_o <= pwdata_i[`AGC_OFFSET_BITS-1:0];
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // Read-back
    always_comb begin
        case (paddr_i)
            `ADDR_CTRL:         rd_mux = DW'(enable_o);
            `ADDR_SCALE_DELTA:  rd_mux = DW'(scale_delta_o);
            `ADDR_OFFSET_DELTA: rd_mux = DW'($unsigned(offset_delta_o));
            `ADDR_SCALE:        rd_mux = DW'(scale_i);
            `ADDR_OFFSET:       rd_mux = DW'(offset_i);   // Sign-extended
            `ADDR_SUMSQ:        rd_mux = DW'(sumsq_i);
            `ADDR_GT:           rd_mux = DW'(gt_i);
            `ADDR_LT:           rd_mux = DW'(lt_i);
            `ADDR_LOOPS:        rd_mux = DW'(loops_i);
            default:            rd_mux = '0;
        endcase
    end

    // Captured in the setup phase, valid during access
    always_ff @(posedge aclk) begin
        if (wb_rst_i)
            prdata_o <= '0;
        else if (psel_i && !penable_i && !pwrite_i)
            prdata_o <= rd_mux;
    end

endmodule

//--- src/agc_loop_fsm.sv
`timescale 1ns/1ps
`include "agc_defines.svh"

module agc_loop_fsm (
    input  logic                          aclk,
    input  logic                          wb_rst_i,
    input  logic                          enable_i,
    input  agc_pkg::scale_t               scale_delta_i,
    input  agc_pkg::offset_t              offset_delta_i,
    input  logic                          scale_wr_i,
    input  logic                          offset_wr_i,
    input  logic [`AGC_APB_DATA_BITS-1:0] wr_data_i,
    input  logic                          timer_done_i,
    input  agc_pkg::sumsq_t               sumsq_i,
    input  agc_pkg::count_t               gt_i,
    input  agc_pkg::count_t               lt_i,
    output logic                          timer_start_o,
    output agc_pkg::count_t               timer_cycles_o,
    output logic                          stats_clear_o,
    output logic                          capture_o,
    output agc_pkg::scale_t               scale_o,
    output agc_pkg::offset_t              offset_o,
    output agc_pkg::count_t               loops_o
);

    localparam int CW = `AGC_COUNT_BITS;

    localparam agc_pkg::sumsq_t MS_HI     = agc_pkg::sumsq_t'(`AGC_TARGET_MS + `AGC_MS_ERR);
    localparam agc_pkg::sumsq_t MS_LO     = agc_pkg::sumsq_t'(`AGC_TARGET_MS - `AGC_MS_ERR);
    localparam agc_pkg::scale_t SCALE_MIN = agc_pkg::scale_t'(`AGC_SCALE_MIN);
    localparam agc_pkg::scale_t SCALE_MAX = agc_pkg::scale_t'(`AGC_SCALE_MAX);
    localparam logic [CW:0]     OFS_ERR   = (CW+1)'(`AGC_OFFSET_ERR);

    localparam agc_pkg::count_t BOOT_N  = agc_pkg::count_t'(`AGC_BOOT_CYCLES);
    localparam agc_pkg::count_t WIN_N   = agc_pkg::count_t'(`AGC_WINDOW_CYCLES);
    // CALC and APPLY already used two cycles of the next window
    localparam agc_pkg::count_t REWIN_N = agc_pkg::count_t'(`AGC_WINDOW_CYCLES - 2);

    agc_pkg::loop_state_t state;
    logic                 boot_started;
    agc_pkg::sumsq_t      ms;
    agc_pkg::scale_t      scale_step, new_scale;
    agc_pkg::offset_t     offset_step, new_offset;

    assign timer_start_o  = (state == agc_pkg::BOOT && !boot_started) ||
                            (state == agc_pkg::CLEAR) || (state == agc_pkg::APPLY);
    assign timer_cycles_o = (state == agc_pkg::BOOT)  ? BOOT_N :
                            (state == agc_pkg::CLEAR) ? WIN_N  : REWIN_N;
    assign stats_clear_o  = (state == agc_pkg::CLEAR);
    assign capture_o      = (state == agc_pkg::MEASURE) && timer_done_i;

    assign ms = sumsq_i >> `AGC_MS_SHIFT;   // Mean square per sample

    //////////////////////////////
    // Update rules
    always_comb begin
        scale_step = scale_o;
        if (ms > MS_HI && scale_o > SCALE_MIN)
            scale_step = scale_o - scale_delta_i;   // Too loud
        else if (ms < MS_LO && scale_o < SCALE_MAX)
            scale_step = scale_o + scale_delta_i;

        offset_step = offset_o;
        if ({1'b0, gt_i} > {1'b0, lt_i} + OFS_ERR)
            offset_step = offset_o - offset_delta_i;
        else if ({1'b0, lt_i} > {1'b0, gt_i} + OFS_ERR)
            offset_step = offset_o + offset_delta_i;
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state        <= agc_pkg::BOOT;
            boot_started <= 1'b0;
            scale_o      <= agc_pkg::scale_t'(`AGC_START_SCALE);
            offset_o     <= agc_pkg::offset_t'(`AGC_START_OFFSET);
            loops_o      <= '0;
        end else begin
            case (state)
                agc_pkg::BOOT: begin
                    boot_started <= 1'b1;
                    if (timer_done_i) state <= agc_pkg::CLEAR;
                end
                agc_pkg::CLEAR: state <= agc_pkg::MEASURE;
                agc_pkg::MEASURE: begin
                    if (timer_done_i) state <= agc_pkg::CALC;   // Capture goes out now
                end
                agc_pkg::CALC: state <= agc_pkg::APPLY;
                agc_pkg::APPLY: begin
                    if (enable_i) begin
                        scale_o  <= new_scale;
                        offset_o <= new_offset;
                    end
                    loops_o <= loops_o + 1'b1;
                    state   <= agc_pkg::MEASURE;
                end
                default: state <= agc_pkg::BOOT;
            endcase

            // Hand loads only with the loop off
            if (!enable_i && scale_wr_i)
                scale_o <= wr_data_i[`AGC_SCALE_BITS-1:0];
            if (!enable_i && offset_wr_i)
                offset_o <= wr_data_i[`AGC_OFFSET_BITS-1:0];
        end
    end

    always_ff @(posedge aclk) begin
        if (state == agc_pkg::CALC) begin
            new_scale  <= enable_i ? scale_step  : scale_o;
            new_offset <= enable_i ? offset_step : offset_o;
        end
    end

endmodule

//--- src/agc_window_timer.sv
`timescale 1ns/1ps

module agc_window_timer (
    input  logic            aclk,
    input  logic            wb_rst_i,
    input  logic            start_i,
    input  agc_pkg::count_t cycles_i,
    output logic            done_o
);

    agc_pkg::count_t cnt_q;
    logic            busy_q;

    // One pulse, cycles_i clocks after the start
    assign done_o = busy_q && (cnt_q == '0);

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            cnt_q  <= cycles_i - 1'b1;
        end else if (busy_q) begin
            if (cnt_q == '0)
                busy_q <= 1'b0;
            else
                cnt_q <= cnt_q - 1'b1;
        end
    end

endmodule

//--- src/agc_sample_stats.sv
`timescale 1ns/1ps
`include "agc_defines.svh"

module agc_sample_stats (
    input  logic                 aclk,
    input  logic                 wb_rst_i,
    input  logic                 clear_i,
    input  logic                 capture_i,
    input  agc_pkg::sample_out_t dat_i,
    output agc_pkg::sumsq_t      sumsq_o,
    output agc_pkg::count_t      gt_o,
    output agc_pkg::count_t      lt_o
);

    localparam int SQ_W = 2 * `AGC_OUT_BITS;
    localparam int NW   = $clog2(`AGC_LANES + 1);
    localparam int SW   = `AGC_SUMSQ_BITS;
    localparam int CW   = `AGC_COUNT_BITS;

    logic signed [SQ_W-1:0] lane_sq;
    logic [NW-1:0]          cyc_gt, cyc_lt;
    logic [SW:0]            sq_wide;
    agc_pkg::sumsq_t        cyc_sq, acc_sq, tot_sq;
    agc_pkg::count_t        acc_gt, acc_lt, tot_gt, tot_lt;

    function automatic agc_pkg::count_t add_cnt(input agc_pkg::count_t a,
                                                input logic [NW-1:0] b);
        logic [CW:0] s;
        s = a + b;
        return s[CW] ? '1 : s[CW-1:0];   // Stick at max
    endfunction

    // This cycle's contribution plus the running totals
    always_comb begin
        cyc_sq  = '0;
        cyc_gt  = '0;
        cyc_lt  = '0;
        lane_sq = '0;
        for (int i = 0; i < `AGC_LANES; i++) begin
            lane_sq = dat_i[i] * dat_i[i];
            cyc_sq  = cyc_sq + agc_pkg::sumsq_t'(lane_sq);
            cyc_gt  = cyc_gt + NW'(dat_i[i] > 0);
            cyc_lt  = cyc_lt + NW'(dat_i[i] < 0);
        end
        sq_wide = acc_sq + cyc_sq;
        tot_sq  = sq_wide[SW] ? '1 : sq_wide[SW-1:0];
        tot_gt  = add_cnt(acc_gt, cyc_gt);
        tot_lt  = add_cnt(acc_lt, cyc_lt);
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            acc_sq  <= '0;
            acc_gt  <= '0;
            acc_lt  <= '0;
            sumsq_o <= '0;
            gt_o    <= '0;
            lt_o    <= '0;
        end else if (clear_i) begin
            acc_sq <= '0;
            acc_gt <= '0;
            acc_lt <= '0;
        end else if (capture_i) begin
            // Current sample closes this window
            sumsq_o <= tot_sq;
            gt_o    <= tot_gt;
            lt_o    <= tot_lt;
            acc_sq  <= '0;
            acc_gt  <= '0;
            acc_lt  <= '0;
        end else begin
            acc_sq <= tot_sq;
            acc_gt <= tot_gt;
            acc_lt <= tot_lt;
        end
    end

endmodule

//--- src/agc_scaler.sv
`timescale 1ns/1ps
`include "agc_defines.svh"

module agc_scaler (
    input  logic                 aclk,
    input  logic                 wb_rst_i,
    input  agc_pkg::sample_in_t  dat_i,
    input  agc_pkg::scale_t      scale_i,
    input  agc_pkg::offset_t     offset_i,
    output agc_pkg::sample_out_t dat_o
);

    // Product width plus one bit for the offset sum
    localparam int PW = `AGC_IN_BITS + `AGC_SCALE_BITS + 2;
    localparam logic signed [PW-1:0] OUT_MAX = PW'(2 ** (`AGC_OUT_BITS - 1) - 1);
    localparam logic signed [PW-1:0] OUT_MIN = -PW'(2 ** (`AGC_OUT_BITS - 1));

    logic signed [`AGC_SCALE_BITS:0] scale_s;
    logic signed [PW-1:0]            offset_s;
    logic signed [PW-1:0]            mac_q [`AGC_LANES];

    assign scale_s  = $signed({1'b0, scale_i});   // Always positive
    assign offset_s = PW'(offset_i) <<< (`AGC_SCALE_FRAC - 4);

    function automatic agc_pkg::out_lane_t saturate(input logic signed [PW-1:0] v);
        logic signed [PW-1:0] s;
        s = v >>> `AGC_SCALE_FRAC;
        if (s > OUT_MAX)
            return agc_pkg::out_lane_t'(OUT_MAX);
        if (s < OUT_MIN)
            return agc_pkg::out_lane_t'(OUT_MIN);
        return agc_pkg::out_lane_t'(s);
    endfunction

    //////////////////////////////
    // Stage 1 multiply and offset
    always_ff @(posedge aclk) begin
        for (int i = 0; i < `AGC_LANES; i++) begin
            if (wb_rst_i)
                mac_q[i] <= '0;
            else
                mac_q[i] <= dat_i[i] * scale_s + offset_s;
        end
    end

    //////////////////////////////
    // Stage 2 rescale and clip to 5 bits
    always_ff @(posedge aclk) begin
        if (wb_rst_i)
            dat_o <= '0;
        else
            for (int i = 0; i < `AGC_LANES; i++)
                dat_o[i] <= saturate(mac_q[i]);
    end

endmodule

//--- src/agc_trigger_top.sv
`timescale 1ns/1ps
`include "agc_defines.svh"

module agc_trigger_top (
    input  logic                          aclk,
    input  logic                          wb_rst_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [`AGC_APB_ADDR_BITS-1:0] paddr_i,
    input  logic [`AGC_APB_DATA_BITS-1:0] pwdata_i,
    output logic [`AGC_APB_DATA_BITS-1:0] prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    input  agc_pkg::sample_in_t           dat_i,
    output agc_pkg::sample_out_t          dat_o
);

    logic                          enable, scale_wr, offset_wr;
    logic [`AGC_APB_DATA_BITS-1:0] wr_data;
    agc_pkg::scale_t               scale_delta, scale;
    agc_pkg::offset_t              offset_delta, offset;
    agc_pkg::sumsq_t               sumsq;
    agc_pkg::count_t               gt, lt, loops, timer_cycles;
    logic                          timer_start, timer_done, stats_clear, capture;

    // Register block
    agc_apb_regs u_regs (
        .aclk(aclk),                 .wb_rst_i(wb_rst_i),
        .psel_i(psel_i),             .penable_i(penable_i),
        .pwrite_i(pwrite_i),         .paddr_i(paddr_i),
        .pwdata_i(pwdata_i),         .scale_i(scale),
        .offset_i(offset),           .sumsq_i(sumsq),
        .gt_i(gt),                   .lt_i(lt),
        .loops_i(loops),             .prdata_o(prdata_o),
        .pready_o(pready_o),         .pslverr_o(pslverr_o),
        .enable_o(enable),           .scale_delta_o(scale_delta),
        .offset_delta_o(offset_delta),
        .scale_wr_o(scale_wr),       .offset_wr_o(offset_wr),
        .wr_data_o(wr_data)
    );

    // Control loop
    agc_loop_fsm u_fsm (
        .aclk(aclk),                 .wb_rst_i(wb_rst_i),
        .enable_i(enable),           .scale_delta_i(scale_delta),
        .offset_delta_i(offset_delta),
        .scale_wr_i(scale_wr),       .offset_wr_i(offset_wr),
        .wr_data_i(wr_data),         .timer_done_i(timer_done),
        .sumsq_i(sumsq),             .gt_i(gt),
        .lt_i(lt),                   .timer_start_o(timer_start),
        .timer_cycles_o(timer_cycles),
        .stats_clear_o(stats_clear), .capture_o(capture),
        .scale_o(scale),             .offset_o(offset),
        .loops_o(loops)
    );

    agc_window_timer u_timer (
        .aclk(aclk),                 .wb_rst_i(wb_rst_i),
        .start_i(timer_start),       .cycles_i(timer_cycles),
        .done_o(timer_done)
    );

    // Window statistics on the output stream
    agc_sample_stats u_stats (
        .aclk(aclk),                 .wb_rst_i(wb_rst_i),
        .clear_i(stats_clear),       .capture_i(capture),
        .dat_i(dat_o),               .sumsq_o(sumsq),
        .gt_o(gt),                   .lt_o(lt)
    );

    agc_scaler u_scaler (
        .aclk(aclk),                 .wb_rst_i(wb_rst_i),
        .dat_i(dat_i),               .scale_i(scale),
        .offset_i(offset),           .dat_o(dat_o)
    );

endmodule

//--- testbench/tb_agc_trigger.sv
`timescale 1ns/1ps
`include "agc_defines.svh"

module tb_agc_trigger;

    localparam int MAX_CMDS = 64;

    logic                          aclk = 1'b0;
    logic                          wb_rst_i, psel_i, penable_i, pwrite_i;
    logic [`AGC_APB_ADDR_BITS-1:0] paddr_i;
    logic [`AGC_APB_DATA_BITS-1:0] pwdata_i, prdata_o;
    logic                          pready_o, pslverr_o;
    agc_pkg::sample_in_t           dat_i;
    agc_pkg::sample_out_t          dat_o;

    logic [31:0] stim [3*MAX_CMDS];   // Opcode, argument, expected
    logic [31:0] sdelta, odelta;      // Step sizes the DUT should be using
    int          n_cmds, errors;

    agc_trigger_top DUT (.*);

    always #50 aclk = ~aclk;

    //////////////////////////////
    // Helpers
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Setup then access, read data taken in the middle of access
    task automatic apb_xfer(input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge aclk);
        psel_i   <= 1'b1;
        pwrite_i <= wr;
        paddr_i  <= addr;
        pwdata_i <= wdata;
        @(posedge aclk);
        penable_i <= 1'b1;
        @(negedge aclk);
        rdata = prdata_o;
        check_value("pready_o", {31'd0, pready_o}, 32'd1);     // No wait states
        check_value("pslverr_o", {31'd0, pslverr_o}, 32'd0);
        @(posedge aclk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    // Poll LOOPS until it has moved on by n
    task automatic wait_loops(input int n);
        logic [31:0] base, cur;
        apb_xfer(1'b0, `ADDR_LOOPS, '0, base);
        do
            apb_xfer(1'b0, `ADDR_LOOPS, '0, cur);
        while (cur - base < n);
    endtask

    // Lanes below fixed get val, the rest 0 or -1 at random
    task automatic drive_lanes(input logic [11:0] val, input int fixed);
        agc_pkg::sample_in_t v;
        for (int i = 0; i < `AGC_LANES; i++)
            v[i] = (i < fixed) ? val : -12'($urandom % 2);
        @(posedge aclk);
        dat_i <= v;
    endtask

    // Follow n loop updates, each against the update rule
    task automatic check_steps(input bit is_offset, input int n);
        logic [7:0]  addr;
        logic [31:0] prev, now, sq, gt, lt, exp;
        logic [15:0] ofs;
        addr = is_offset ? `ADDR_OFFSET : `ADDR_SCALE;
        wait_loops(1);   // Line up with a window boundary
        apb_xfer(1'b0, addr, '0, prev);
        repeat (n) begin
            wait_loops(1);
            apb_xfer(1'b0, `ADDR_SUMSQ, '0, sq);
            apb_xfer(1'b0, `ADDR_GT, '0, gt);
            apb_xfer(1'b0, `ADDR_LT, '0, lt);
            apb_xfer(1'b0, addr, '0, now);
            exp = prev;
            if (is_offset) begin
                ofs = prev[15:0];
                if (gt > lt + `AGC_OFFSET_ERR)
                    ofs = ofs - odelta[15:0];   // Too many positive outputs
                else if (lt > gt + `AGC_OFFSET_ERR)
                    ofs = ofs + odelta[15:0];
                exp = {{16{ofs[15]}}, ofs};
            end else if ((sq >> `AGC_MS_SHIFT) > `AGC_TARGET_MS + `AGC_MS_ERR
                         && prev > `AGC_SCALE_MIN)
                exp = prev - sdelta;
            else if ((sq >> `AGC_MS_SHIFT) < `AGC_TARGET_MS - `AGC_MS_ERR
                     && prev < `AGC_SCALE_MAX)
                exp = prev + sdelta;
            check_value(is_offset ? "OFFSET" : "SCALE", now, exp);
            prev = now;
        end
    endtask

    //////////////////////////////
    // Stim command loop
    initial begin
        int          op, err_before;
        logic [31:0] arg, exp, rd;
        void'($urandom(10481));
        wb_rst_i  = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        dat_i     = '0;
        sdelta    = `AGC_START_SCALE_DELTA;
        odelta    = `AGC_START_OFFSET_DELTA;
        foreach (stim[i])
            stim[i] = '0;   // Opcode 0 marks the end
        $readmemh("testbench/agc_stim.txt", stim);
        while (n_cmds < MAX_CMDS && stim[3*n_cmds] != 0)
            n_cmds++;
        repeat (4) @(posedge aclk);
        wb_rst_i <= 1'b0;

        for (int pc = 0; pc < n_cmds; pc++) begin
            op         = stim[3*pc];
            arg        = stim[3*pc+1];
            exp        = stim[3*pc+2];
            err_before = errors;
            case (op)
                1: begin
                    apb_xfer(1'b1, arg[7:0], exp, rd);
                    if (arg[7:0] == `ADDR_SCALE_DELTA)
                        sdelta = exp;
                    if (arg[7:0] == `ADDR_OFFSET_DELTA)
                        odelta = exp;
                end
                2: begin
                    apb_xfer(1'b0, arg[7:0], '0, rd);
                    check_value($sformatf("prdata_o[0x%02h]", arg[7:0]), rd, exp);
                end
                3: drive_lanes(arg[11:0], `AGC_LANES);
                4: wait_loops(arg);
                5: begin
                    repeat (4) @(posedge aclk);   // Past the two pipeline stages
                    @(negedge aclk);
                    for (int i = 0; i < `AGC_LANES; i++)
                        check_value($sformatf("dat_o[%0d]", i), {27'd0, dat_o[i]}, exp);
                end
                6: drive_lanes(arg[11:0], 5);
                7: check_steps(1'b0, arg);
                8: check_steps(1'b1, arg);
                default: begin
                    $display("Stim line %0d has the unknown opcode %0d", pc, op);
                    errors++;
                end
            endcase
            $display("test %0d op %0d %s", pc, op, (errors == err_before) ? "ok" : "failed");
        end
        $display("%0d tests, %0d errors", n_cmds, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // Budget of one window plus margin per command
    initial begin
        @(negedge wb_rst_i);
        #(n_cmds * (`AGC_WINDOW_CYCLES + 64) * 100);
        $display("Timeout, the stim commands did not complete in time");
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- testbench/agc_stim.txt
// opcode  arg (address or sample)  expected (write data or value)
// 1 write, 2 read, 3 set lanes, 4 wait loops, 5 check dat_o, 6 biased lanes, 7 scale, 8 offset
2 00 1
2 04 1E
2 08 19
2 0C 5DC
2 10 0
1 00 0
1 0C 1000
3 F9C 0
5 0 10
1 0C 800
1 10 10
3 FFB 0
5 0 1E
3 006 0
4 3 0
2 14 8000
2 18 800
1 0C CE4
1 04 3E8
3 7FF 0
1 00 1
7 5 0
1 00 0
1 0C 1000
1 10 0
1 08 40
6 002 0
1 00 1
8 3 0

//--- project.f
+incdir+src
src/agc_pkg.sv
src/agc_apb_regs.sv
src/agc_loop_fsm.sv
src/agc_window_timer.sv
src/agc_sample_stats.sv
src/agc_scaler.sv
src/agc_trigger_top.sv
testbench/tb_agc_trigger.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_agc_trigger -o tb_agc_trigger
./obj_dir/tb_agc_trigger | tee sim.log
grep -q "Finished with no errors" sim.log
